// ==== list.f ====
hdl/imu_pkg.sv
hdl/imu_sensor_ctrl.sv
hdl/euler_line_fmt.sv
hdl/uart_tx.sv
hdl/imu_uart_top.sv
testbench/tb_imu_uart_top.sv

// ==== Bender.yml ====
package:
  name: imu_uart

sources:
  - files:
      - hdl/imu_pkg.sv
      - hdl/imu_sensor_ctrl.sv
      - hdl/euler_line_fmt.sv
      - hdl/uart_tx.sv
      - hdl/imu_uart_top.sv
  - target: test
    files:
      - testbench/tb_imu_uart_top.sv

// ==== testbench/tb_imu_uart_top.sv ====
// ==============================
// Testbench for imu_uart_top with a register-level sensor model
// Runs with small timing parameters: normal, bad chip ID, nack
// ==============================
`timescale 1ns/1ns
`default_nettype none

module tb_imu_uart_top import imu_pkg::*; ();

    localparam int STARTUP_CYC  = 50;
    localparam int CALIB_CYC    = 100;
    localparam int SAMPLE_CYC   = 400;
    localparam int CPB          = 4;
    localparam int FRAME_CYC    = 10 * CPB;
    localparam int LINE_CYC     = LINE_LEN * FRAME_CYC;
    localparam int TIMEOUT_CYC  = 2 * (STARTUP_CYC + CALIB_CYC + 12 * SAMPLE_CYC + 12 * LINE_CYC);
    localparam int NORMAL_LINES = 10;
    localparam int NACK_BURST   = 3;       // Burst that gets the nack
    localparam int RUN_NORMAL   = 0;
    localparam int RUN_BAD_ID   = 1;
    localparam int RUN_NACK     = 2;
    localparam logic [16*8-1:0] HEX_DIGITS = "0123456789ABCDEF";

    logic       CLK;
    logic       rst;
    logic       req_valid;
    logic       req_ready;
    logic       req_write;
    reg_addr_t  req_addr;
    byte_t      req_wdata;
    burst_len_t req_len;
    logic       rsp_valid;
    byte_t      rsp_data;
    logic       nack;
    logic       tx;
    logic       init_done;
    logic       error;
    logic       sending;

    // Sensor model and scoreboard state
    byte_t                 regs [256];
    byte_t                 rsp_fifo [$];
    logic [LINE_LEN*8-1:0] exp_lines [$];
    int                    rsp_delay;
    int                    req_count;
    int                    wr_count;
    int                    burst_count;
    logic                  stalled;
    logic [19:0]           held_fields;
    logic                  init_seen;
    logic                  nack_sent;
    logic                  freeze;      // Hold req_ready low so the line path drains
    int                    run_mode;
    int                    idle_cnt;
    int                    lines_run;
    int                    lines_total;
    int                    cyc_cnt;
    logic [31:0]           rng_state;

    imu_uart_top #(
        .STARTUP_CYCLES (STARTUP_CYC),
        .CALIB_CYCLES   (CALIB_CYC),
        .SAMPLE_CYCLES  (SAMPLE_CYC),
        .CLKS_PER_BIT   (CPB)
    ) imu_uart_top_i (
        .CLK         (CLK),
        .rst         (rst),
        .req_valid_o (req_valid),
        .req_ready_i (req_ready),
        .req_write_o (req_write),
        .req_addr_o  (req_addr),
        .req_wdata_o (req_wdata),
        .req_len_o   (req_len),
        .rsp_valid_i (rsp_valid),
        .rsp_data_i  (rsp_data),
        .nack_i      (nack),
        .tx_o        (tx),
        .init_done_o (init_done),
        .error_o     (error),
        .sending_o   (sending)
    );

    always #10 CLK = ~CLK;

    // ==============================
    // Helpers
    // ==============================
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic byte_t hex_digit(input logic [3:0] v);
        return HEX_DIGITS[(15 - v) * 8 +: 8];
    endfunction

    function automatic logic [31:0] hex_word(input angle_t a);
        return {hex_digit(a[15:12]), hex_digit(a[11:8]), hex_digit(a[7:4]), hex_digit(a[3:0])};
    endfunction

    function automatic logic [LINE_LEN*8-1:0] expected_line(input angle_t h, input angle_t r,
                                                            input angle_t p);
        return {"H:", hex_word(h), " R:", hex_word(r), " P:", hex_word(p), ASCII_NEWLINE};
    endfunction

    // Address and data of configuration write k
    function automatic logic [15:0] config_write(input int k);
        case (k)
            0:       return {REG_OPR_MODE, MODE_CONFIG};
            1:       return {REG_PWR_MODE, PWR_NORMAL};
            2:       return {REG_UNIT_SEL, UNITS_DEGREES};
            default: return {REG_OPR_MODE, MODE_NDOF};
        endcase
    endfunction

    task automatic stop_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0t ns: %s", $time, what);
        stop_run();
    endtask

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
            stop_run();
        end
    endtask

    // ==============================
    // Sensor model on the request port
    // ==============================
    always @(negedge CLK) begin : sensor_model
        logic        ready_now;
        logic [19:0] fields;
        logic [15:0] cfg;
        angle_t      h;
        angle_t      r;
        angle_t      p;
        int          i;
        fields    = {req_write, req_addr, req_wdata, req_len};
        rsp_valid = 1'b0;
        nack      = 1'b0;
        if (rst) begin
            req_ready   = 1'b0;
            rsp_data    = '0;
            rsp_fifo.delete();
            exp_lines.delete();
            rsp_delay   = 0;
            req_count   = 0;
            wr_count    = 0;
            burst_count = 0;
            stalled     = 1'b0;
            init_seen   = 1'b0;
            nack_sent   = 1'b0;
            regs[REG_CHIP_ID] = (run_mode == RUN_BAD_ID) ? 8'h5A : CHIP_ID_VALUE;
            for (i = 0; i < 6; i++) regs[REG_EULER_BASE + i] = byte_t'(next_rand() >> 24);
        end else begin
            if (stalled) begin
                assert (req_valid) else report_failure("request dropped while stalled");
                expect_eq("req_write_o/addr/wdata/len", held_fields, fields);
            end
            if (wr_count < 4) begin
                assert (!init_done) else report_failure("init_done_o high before config writes");
            end
            if (init_seen) begin
                assert (init_done) else report_failure("init_done_o fell after rising");
            end
            init_seen = init_seen | init_done;
            if (run_mode == RUN_NORMAL) begin
                assert (!error) else report_failure("error_o set during the normal run");
            end

            // Read data, with random gaps
            if (rsp_fifo.size() > 0) begin
                if (rsp_delay > 0) begin
                    rsp_delay--;
                end else if (run_mode == RUN_NACK && burst_count == NACK_BURST &&
                             rsp_fifo.size() == 3 && !nack_sent) begin
                    nack      = 1'b1;
                    nack_sent = 1'b1;
                    rsp_fifo.delete();
                    void'(exp_lines.pop_back());    // That sample never completes
                end else begin
                    rsp_valid = 1'b1;
                    rsp_data  = rsp_fifo.pop_front();
                    rsp_delay = next_rand() >> 30;
                end
            end

            ready_now = !freeze && ((next_rand() >> 30) != 0);
            if (req_valid && ready_now) begin
                if (req_count == 0) begin
                    expect_eq("req_write_o", 0, req_write);
                    expect_eq("req_addr_o", REG_CHIP_ID, req_addr);
                    expect_eq("req_len_o", 1, req_len);
                    rsp_fifo.push_back(regs[REG_CHIP_ID]);
                end else if (req_count <= 4) begin
                    cfg = config_write(req_count - 1);
                    expect_eq("req_write_o", 1, req_write);
                    expect_eq("req_addr_o", cfg[15:8], req_addr);
                    expect_eq("req_wdata_o", cfg[7:0], req_wdata);
                    regs[req_addr] = req_wdata;
                    wr_count++;
                end else begin
                    expect_eq("req_write_o", 0, req_write);
                    expect_eq("req_addr_o", REG_EULER_BASE, req_addr);
                    expect_eq("req_len_o", EULER_BYTES, req_len);
                    assert (init_done) else report_failure("burst read before init_done_o");
                    for (i = 0; i < 6; i++) rsp_fifo.push_back(regs[REG_EULER_BASE + i]);
                    h = {regs[REG_EULER_BASE + 1], regs[REG_EULER_BASE]};
                    r = {regs[REG_EULER_BASE + 3], regs[REG_EULER_BASE + 2]};
                    p = {regs[REG_EULER_BASE + 5], regs[REG_EULER_BASE + 4]};
                    exp_lines.push_back(expected_line(h, r, p));
                    for (i = 0; i < 6; i++) regs[REG_EULER_BASE + i] = byte_t'(next_rand() >> 24);
                    burst_count++;
                end
                rsp_delay = next_rand() >> 29;
                req_count++;
            end
            stalled     = req_valid && !ready_now && !nack;
            held_fields = fields;
            req_ready   = ready_now;
        end
    end

    // ==============================
    // UART decoder and line scoreboard
    // ==============================
    always begin : uart_decoder
        byte_t                 ch;
        logic                  busy_at_start;
        logic [LINE_LEN*8-1:0] rx_line;
        logic [LINE_LEN*8-1:0] exp_line;
        int                    rx_cnt;
        int                    b;
        @(negedge tx);
        repeat (CPB / 2) @(negedge CLK);     // Middle of the start bit
        assert (!tx) else report_failure("start bit on tx_o too short");
        busy_at_start = sending;
        for (b = 0; b < 8; b++) begin
            repeat (CPB) @(negedge CLK);
            ch[b] = tx;
        end
        repeat (CPB) @(negedge CLK);
        assert (tx) else report_failure("missing stop bit on tx_o");
        if (ch != ASCII_NEWLINE) begin
            assert (busy_at_start) else report_failure("character on tx_o with sending_o low");
        end
        rx_line = {rx_line[LINE_LEN*8-9:0], ch};
        rx_cnt++;
        if (ch == ASCII_NEWLINE) begin
            assert (exp_lines.size() > 0) else report_failure("line arrived with no burst behind it");
            exp_line = exp_lines.pop_front();
            assert (rx_cnt == LINE_LEN && rx_line == exp_line) else begin
                $display("[FAIL] %0t ns: tx_o line expected \"%s\", got \"%s\"", $time,
                         exp_line[LINE_LEN*8-1:8], rx_line[LINE_LEN*8-1:8]);
                stop_run();
            end
            rx_cnt = 0;
            lines_run++;
            lines_total++;
        end
    end

    // Line must be idle once sending_o has been low for a frame
    always @(negedge CLK) begin : idle_monitor
        if (rst || sending) begin
            idle_cnt = 0;
        end else if (idle_cnt < FRAME_CYC) begin
            idle_cnt++;
        end
        if (idle_cnt >= FRAME_CYC) begin
            assert (tx) else report_failure("tx_o active after sending_o low for a frame");
        end
    end

    always @(posedge CLK) begin : timeout_guard
        if (rst) cyc_cnt <= 0;
        else     cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= TIMEOUT_CYC) begin
            report_failure("timeout, a run or its sampled lines did not finish in time");
        end
    end

    // ==============================
    // Test sequence
    // ==============================
    task automatic run_test(input int mode);
        @(negedge CLK);
        rst       = 1'b1;
        run_mode  = mode;
        freeze    = 1'b0;
        lines_run = 0;
        repeat (5) @(negedge CLK);
        rst = 1'b0;
        if (mode == RUN_NORMAL) begin
            while (lines_run < NORMAL_LINES) @(posedge CLK);
        end else begin
            while (!error) @(negedge CLK);
            if (mode == RUN_BAD_ID) expect_eq("request count", 1, req_count);
            else assert (nack_sent) else report_failure("error_o set without a nack");
            repeat (200) begin
                @(negedge CLK);
                assert (error && !req_valid) else report_failure("request issued after error_o");
            end
        end
        freeze = 1'b1;                       // Let the buffered lines drain
        while (exp_lines.size() > 0 || rsp_fifo.size() > 0 || idle_cnt < FRAME_CYC) begin
            @(posedge CLK);
        end
    endtask

    initial begin
        CLK         = 1'b0;
        rst         = 1'b1;
        req_ready   = 1'b0;
        rsp_valid   = 1'b0;
        rsp_data    = '0;
        nack        = 1'b0;
        freeze      = 1'b0;
        run_mode    = RUN_NORMAL;
        lines_run   = 0;
        lines_total = 0;
        rng_state   = 32'h850e_f95a;
        run_test(RUN_NORMAL);
        run_test(RUN_BAD_ID);
        run_test(RUN_NACK);
        if (lines_total < 8) begin
            report_failure("fewer than 8 lines were checked");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/imu_uart_top.sv ====
// ==============================
// Sensor controller, line formatter and UART transmitter
// Expects an external byte-level I2C master on the request port
// ==============================
`timescale 1ns/1ns
`default_nettype none

module imu_uart_top import imu_pkg::*; #(
    parameter int STARTUP_CYCLES = STARTUP_CYCLES_DEF,
    parameter int CALIB_CYCLES   = CALIB_CYCLES_DEF,
    parameter int SAMPLE_CYCLES  = SAMPLE_CYCLES_DEF,
    parameter int CLKS_PER_BIT   = CLKS_PER_BIT_DEF
) (
    input  wire         CLK,
    input  wire         rst,
    // Register request port
    output logic        req_valid_o,
    input  wire         req_ready_i,
    output logic        req_write_o,
    output reg_addr_t   req_addr_o,
    output byte_t       req_wdata_o,
    output burst_len_t  req_len_o,
    input  wire         rsp_valid_i,
    input  wire byte_t  rsp_data_i,
    input  wire         nack_i,
    // Serial output and status
    output logic        tx_o,
    output logic        init_done_o,
    output logic        error_o,
    output logic        sending_o
);

    logic   sample_valid;
    logic   sample_ready;
    angle_t heading;
    angle_t roll;
    angle_t pitch;
    logic   char_valid;
    logic   char_ready;
    byte_t  char_data;

    imu_sensor_ctrl #(
        .STARTUP_CYCLES (STARTUP_CYCLES),
        .CALIB_CYCLES   (CALIB_CYCLES),
        .SAMPLE_CYCLES  (SAMPLE_CYCLES)
    ) u_ctrl (
        .CLK            (CLK),
        .rst            (rst),
        .req_valid_o    (req_valid_o),
        .req_ready_i    (req_ready_i),
        .req_write_o    (req_write_o),
        .req_addr_o     (req_addr_o),
        .req_wdata_o    (req_wdata_o),
        .req_len_o      (req_len_o),
        .rsp_valid_i    (rsp_valid_i),
        .rsp_data_i     (rsp_data_i),
        .nack_i         (nack_i),
        .sample_valid_o (sample_valid),
        .sample_ready_i (sample_ready),
        .heading_o      (heading),
        .roll_o         (roll),
        .pitch_o        (pitch),
        .init_done_o    (init_done_o),
        .error_o        (error_o)
    );

    euler_line_fmt u_fmt (
        .CLK            (CLK),
        .rst            (rst),
        .sample_valid_i (sample_valid),
        .sample_ready_o (sample_ready),
        .heading_i      (heading),
        .roll_i         (roll),
        .pitch_i        (pitch),
        .char_valid_o   (char_valid),
        .char_ready_i   (char_ready),
        .char_data_o    (char_data),
        .sending_o      (sending_o)
    );

    uart_tx #(
        .CLKS_PER_BIT   (CLKS_PER_BIT)
    ) u_tx (
        .CLK            (CLK),
        .rst            (rst),
        .char_valid_i   (char_valid),
        .char_ready_o   (char_ready),
        .char_data_i    (char_data),
        .tx_o           (tx_o)
    );

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
// ==============================
// 8N1 transmitter, one byte per 10 bit periods
// Accepts a byte only while idle
// ==============================
`timescale 1ns/1ns
`default_nettype none

module uart_tx import imu_pkg::*; #(
    parameter int CLKS_PER_BIT = CLKS_PER_BIT_DEF
) (
    input  wire         CLK,
    input  wire         rst,
    input  wire         char_valid_i,
    output logic        char_ready_o,
    input  wire byte_t  char_data_i,
    output logic        tx_o
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    logic             busy_q;
    logic [CNT_W-1:0] clk_cnt_q;    // Position within a bit period
    logic [3:0]       bit_cnt_q;    // 0 start, 1-8 data, 9 stop
    logic [9:0]       frame_q;

    assign char_ready_o = !busy_q;
    assign tx_o         = busy_q ? frame_q[0] : 1'b1;   // Idle high

    always_ff @(posedge CLK) begin
        if (rst) begin
            busy_q    <= 1'b0;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
        end else if (!busy_q) begin
            if (char_valid_i) begin
                busy_q    <= 1'b1;
                clk_cnt_q <= '0;
                bit_cnt_q <= '0;
            end
        end else if (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt_q <= '0;
            if (bit_cnt_q == 4'd9) begin
                busy_q <= 1'b0;         // Stop bit done
            end else begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
    end

    // Frame shifts out LSB first
    always_ff @(posedge CLK) begin
        if (!busy_q && char_valid_i) begin
            frame_q <= {1'b1, char_data_i, 1'b0};
        end else if (busy_q && clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1)) begin
            frame_q <= {1'b1, frame_q[9:1]};
        end
    end

endmodule

`default_nettype wire

// ==== hdl/euler_line_fmt.sv ====
// ==============================
// One-sample line buffer, streams H:hhhh R:rrrr P:pppp and newline
// ==============================
`timescale 1ns/1ns
`default_nettype none

module euler_line_fmt import imu_pkg::*; (
    input  wire          CLK,
    input  wire          rst,
    input  wire          sample_valid_i,
    output logic         sample_ready_o,
    input  wire angle_t  heading_i,
    input  wire angle_t  roll_i,
    input  wire angle_t  pitch_i,
    output logic         char_valid_o,
    input  wire          char_ready_i,
    output byte_t        char_data_o,
    output logic         sending_o
);

    logic                  full_q;
    logic [CHAR_IDX_W-1:0] char_idx_q;
    angle_t                heading_q;
    angle_t                roll_q;
    angle_t                pitch_q;
    logic                  last_xfer;

    function automatic byte_t hex_char(input logic [3:0] nib);
        return (nib < 4'd10) ? 8'h30 + nib : 8'h37 + nib;   // 0-9, A-F
    endfunction

    // Nibble pos 0 is the most significant
    function automatic logic [3:0] nibble_at(input angle_t a, input logic [1:0] pos);
        angle_t s;
        s = a << {pos, 2'b00};
        return s[15:12];
    endfunction

    assign last_xfer      = char_valid_o && char_ready_i &&
                            (char_idx_q == CHAR_IDX_W'(LINE_LEN - 1));
    assign sample_ready_o = !full_q || last_xfer;   // Reload as the newline leaves
    assign char_valid_o   = full_q;
    assign sending_o      = full_q;

    always_ff @(posedge CLK) begin
        if (rst) begin
            full_q     <= 1'b0;
            char_idx_q <= '0;
        end else if (sample_valid_i && sample_ready_o) begin
            full_q     <= 1'b1;
            char_idx_q <= '0;
        end else if (last_xfer) begin
            full_q     <= 1'b0;
            char_idx_q <= '0;
        end else if (char_valid_o && char_ready_i) begin
            char_idx_q <= char_idx_q + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (sample_valid_i && sample_ready_o) begin
            heading_q <= heading_i;
            roll_q    <= roll_i;
            pitch_q   <= pitch_i;
        end
    end

    always_comb begin
        unique case (char_idx_q)
            5'd0:                    char_data_o = "H";
            5'd7:                    char_data_o = "R";
            5'd14:                   char_data_o = "P";
            5'd1, 5'd8, 5'd15:       char_data_o = ":";
            5'd6, 5'd13:             char_data_o = " ";
            5'd2, 5'd3, 5'd4, 5'd5:
                char_data_o = hex_char(nibble_at(heading_q, 2'(char_idx_q - 5'd2)));
            5'd9, 5'd10, 5'd11, 5'd12:
                char_data_o = hex_char(nibble_at(roll_q, 2'(char_idx_q - 5'd9)));
            5'd16, 5'd17, 5'd18, 5'd19:
                char_data_o = hex_char(nibble_at(pitch_q, 2'(char_idx_q - 5'd16)));
            default:                 char_data_o = ASCII_NEWLINE;
        endcase
    end

    a_idx_range: assert property (@(posedge CLK) disable iff (rst)
        char_idx_q < CHAR_IDX_W'(LINE_LEN));

endmodule

`default_nettype wire

// ==== hdl/imu_sensor_ctrl.sv ====
// ==============================
// Sensor bring-up and periodic Euler burst reads
// Requests wait on req_ready_i forever, error state is terminal
// ==============================
`timescale 1ns/1ns
`default_nettype none

module imu_sensor_ctrl import imu_pkg::*; #(
    parameter int STARTUP_CYCLES = STARTUP_CYCLES_DEF,
    parameter int CALIB_CYCLES   = CALIB_CYCLES_DEF,
    parameter int SAMPLE_CYCLES  = SAMPLE_CYCLES_DEF
) (
    input  wire         CLK,
    input  wire         rst,
    // Register request port
    output logic        req_valid_o,
    input  wire         req_ready_i,
    output logic        req_write_o,
    output reg_addr_t   req_addr_o,
    output byte_t       req_wdata_o,
    output burst_len_t  req_len_o,
    // Read response and acknowledge error
    input  wire         rsp_valid_i,
    input  wire byte_t  rsp_data_i,
    input  wire         nack_i,
    // Sample channel
    output logic        sample_valid_o,
    input  wire         sample_ready_i,
    output angle_t      heading_o,
    output angle_t      roll_o,
    output angle_t      pitch_o,
    // Status
    output logic        init_done_o,
    output logic        error_o
);

    localparam int WAIT_MAX = (STARTUP_CYCLES > CALIB_CYCLES) ? STARTUP_CYCLES : CALIB_CYCLES;
    localparam int WAIT_W   = $clog2(WAIT_MAX + 1);
    localparam int SAMPLE_W = $clog2(SAMPLE_CYCLES + 1);

    ctrl_state_t        state_q;
    logic [WAIT_W-1:0]  wait_cnt_q;
    logic [SAMPLE_W-1:0] sample_cnt_q;
    logic [1:0]         wr_idx_q;       // Which configuration write
    burst_len_t         byte_cnt_q;
    logic [47:0]        burst_q;        // Euler bytes, first byte lowest
    logic               req_xfer;
    logic               sample_due;

    assign req_valid_o = (state_q == ST_ID_REQ) || (state_q == ST_WR_REQ) ||
                         (state_q == ST_RD_REQ);
    assign req_xfer    = req_valid_o && req_ready_i;
    assign sample_due  = (sample_cnt_q == SAMPLE_W'(SAMPLE_CYCLES - 1));

    // Request fields depend on registered state only, so they hold during a stall
    always_comb begin
        req_write_o = 1'b0;
        req_addr_o  = REG_CHIP_ID;
        req_wdata_o = '0;
        req_len_o   = 3'd1;
        unique case (state_q)
            ST_WR_REQ: begin
                req_write_o = 1'b1;
                unique case (wr_idx_q)
                    2'd0: begin
                        req_addr_o  = REG_OPR_MODE;
                        req_wdata_o = MODE_CONFIG;
                    end
                    2'd1: begin
                        req_addr_o  = REG_PWR_MODE;
                        req_wdata_o = PWR_NORMAL;
                    end
                    2'd2: begin
                        req_addr_o  = REG_UNIT_SEL;
                        req_wdata_o = UNITS_DEGREES;
                    end
                    default: begin
                        req_addr_o  = REG_OPR_MODE;
                        req_wdata_o = MODE_NDOF;
                    end
                endcase
            end
            ST_RD_REQ: begin
                req_addr_o = REG_EULER_BASE;
                req_len_o  = EULER_BYTES;
            end
            default: ;
        endcase
    end

    // ==============================
    // Main sequence
    // ==============================
    always_ff @(posedge CLK) begin
        if (rst) begin
            state_q     <= ST_STARTUP;
            wait_cnt_q  <= '0;
            wr_idx_q    <= '0;
            byte_cnt_q  <= '0;
            init_done_o <= 1'b0;
        end else begin
            unique case (state_q)
                ST_STARTUP: begin
                    if (wait_cnt_q == WAIT_W'(STARTUP_CYCLES - 1)) begin
                        wait_cnt_q <= '0;
                        state_q    <= ST_ID_REQ;
                    end else begin
                        wait_cnt_q <= wait_cnt_q + 1'b1;
                    end
                end
                ST_ID_REQ: if (req_xfer) state_q <= ST_ID_WAIT;
                ST_ID_WAIT: begin
                    if (rsp_valid_i) begin
                        state_q <= (rsp_data_i == CHIP_ID_VALUE) ? ST_WR_REQ : ST_ERROR;
                    end
                end
                ST_WR_REQ: begin
                    if (req_xfer) begin
                        wr_idx_q <= wr_idx_q + 1'b1;
                        if (wr_idx_q == 2'd3) state_q <= ST_CALIB;
                    end
                end
                ST_CALIB: begin
                    if (wait_cnt_q == WAIT_W'(CALIB_CYCLES - 1)) begin
                        init_done_o <= 1'b1;
                        state_q     <= ST_IDLE;
                    end else begin
                        wait_cnt_q <= wait_cnt_q + 1'b1;
                    end
                end
                ST_IDLE: if (sample_due) state_q <= ST_RD_REQ;
                ST_RD_REQ: begin
                    if (req_xfer) begin
                        byte_cnt_q <= '0;
                        state_q    <= ST_RD_DATA;
                    end
                end
                ST_RD_DATA: begin
                    if (rsp_valid_i) begin
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                        if (byte_cnt_q == burst_len_t'(EULER_BYTES - 1)) begin
                            state_q <= ST_HANDOFF;
                        end
                    end
                end
                ST_HANDOFF: if (sample_ready_i) state_q <= ST_IDLE;    // Blocks next read
                default: ;   // ST_ERROR holds
            endcase

            if (nack_i) state_q <= ST_ERROR;
        end
    end

    // Sample period runs from each burst request
    always_ff @(posedge CLK) begin
        if (rst) begin
            sample_cnt_q <= '0;
        end else if (state_q == ST_CALIB || (req_xfer && state_q == ST_RD_REQ)) begin
            sample_cnt_q <= '0;
        end else if (!sample_due) begin
            sample_cnt_q <= sample_cnt_q + 1'b1;
        end
    end

    // Little-endian byte packing
    always_ff @(posedge CLK) begin
        if (state_q == ST_RD_DATA && rsp_valid_i) begin
            burst_q <= {rsp_data_i, burst_q[47:8]};
        end
    end

    assign sample_valid_o = (state_q == ST_HANDOFF);
    assign heading_o      = burst_q[15:0];
    assign roll_o         = burst_q[31:16];
    assign pitch_o        = burst_q[47:32];
    assign error_o        = (state_q == ST_ERROR);

    // ==============================
    // Checks
    // ==============================
    a_req_stable: assert property (@(posedge CLK) disable iff (rst)
        req_valid_o && !req_ready_i && !nack_i |=>
            req_valid_o && $stable({req_write_o, req_addr_o, req_wdata_o, req_len_o}));

    // Responses only for an outstanding read
    a_rsp_expected: assert property (@(posedge CLK) disable iff (rst)
        rsp_valid_i |-> (state_q == ST_ID_WAIT || state_q == ST_RD_DATA));

endmodule

`default_nettype wire

// ==== hdl/imu_pkg.sv ====
// ==============================
// Shared definitions for the orientation sensor to UART design
// Timing defaults assume a 25 MHz clock and 115200 baud
// ==============================
`default_nettype none

package imu_pkg;

    // ==============================
    // Types
    // ==============================
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  reg_addr_t;
    typedef logic [15:0] angle_t;
    typedef logic [2:0]  burst_len_t;   // 1 to 6 bytes per read

    typedef enum logic [3:0] {
        ST_STARTUP,     // Power-on wait
        ST_ID_REQ,
        ST_ID_WAIT,
        ST_WR_REQ,      // Four configuration writes
        ST_CALIB,
        ST_IDLE,        // Sample timer running
        ST_RD_REQ,
        ST_RD_DATA,
        ST_HANDOFF,
        ST_ERROR
    } ctrl_state_t;

    // ==============================
    // Sensor registers and values
    // ==============================
    localparam reg_addr_t REG_CHIP_ID    = 8'h00;
    localparam reg_addr_t REG_OPR_MODE   = 8'h3D;
    localparam reg_addr_t REG_PWR_MODE   = 8'h3E;
    localparam reg_addr_t REG_UNIT_SEL   = 8'h3B;
    localparam reg_addr_t REG_EULER_BASE = 8'h1A;   // Heading LSB, then roll, pitch

    localparam byte_t CHIP_ID_VALUE = 8'hA0;
    localparam byte_t MODE_CONFIG   = 8'h00;
    localparam byte_t MODE_NDOF     = 8'h0C;        // 9 axis fusion
    localparam byte_t PWR_NORMAL    = 8'h00;
    localparam byte_t UNITS_DEGREES = 8'h00;

    localparam burst_len_t EULER_BYTES = 3'd6;

    // Timing defaults in clock cycles
    localparam int STARTUP_CYCLES_DEF = 16_250_000;    // 650 ms
    localparam int CALIB_CYCLES_DEF   = 25_000_000;    // 1 s
    localparam int SAMPLE_CYCLES_DEF  = 2_500_000;     // 10 Hz
    localparam int CLKS_PER_BIT_DEF   = 217;

    // ==============================
    // Output line format
    // ==============================
    localparam int    LINE_LEN      = 21;   // H:hhhh R:rrrr P:pppp plus newline
    localparam int    CHAR_IDX_W    = $clog2(LINE_LEN);
    localparam byte_t ASCII_NEWLINE = 8'h0A;

endpackage

`default_nettype wire
